/* Makefile */
TOP = aluApbTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "Result: FAIL"; exit 1; \
	elif ! grep -q "Simulation completed successfully" sim.log; then \
		echo "Result: FAIL (no pass line)"; exit 1; \
	else \
		echo "Result: PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

/* design/aluApbTop.sv */
`timescale 1ns/1ps
`default_nettype none

module aluApbTop #(
    parameter int AddrWidth = 8
) (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  psel,
    input  wire                  penable,
    input  wire                  pwrite,
    input  wire  [AddrWidth-1:0] paddr,
    input  wire  [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic [aluPkg::DataWidth-1:0] op1;
    logic [aluPkg::DataWidth-1:0] op2;
    logic [aluPkg::CtlWidth-1:0]  ctl;
    logic                         start;
    logic                         resValid;
    logic [aluPkg::DataWidth-1:0] result;
    logic                         illegal;
    logic [aluPkg::DataWidth-1:0] resultReg;
    logic [aluPkg::DataWidth-1:0] status;

    aluRegs #(
        .AddrWidth (AddrWidth)
    ) i_aluRegs (
        .clk       (clk),
        .rstN      (rstN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .op1       (op1),
        .op2       (op2),
        .ctl       (ctl),
        .start     (start),
        .resultReg (resultReg),
        .status    (status)
    );

    aluCore i_aluCore (
        .clk      (clk),
        .rstN     (rstN),
        .op1      (op1),
        .op2      (op2),
        .ctl      (ctl),
        .start    (start),
        .resValid (resValid),
        .result   (result),
        .illegal  (illegal)
    );

    aluResult i_aluResult (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .resValid  (resValid),
        .result    (result),
        .illegal   (illegal),
        .resultReg (resultReg),
        .status    (status)
    );

endmodule

`default_nettype wire

/* design/aluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  wire                              clk,
    input  wire                              rstN,
    input  wire  [aluPkg::DataWidth-1:0]     op1,
    input  wire  [aluPkg::DataWidth-1:0]     op2,
    input  wire  [aluPkg::CtlWidth-1:0]      ctl,
    input  wire                              start,
    output logic                             resValid,
    output logic [aluPkg::DataWidth-1:0]     result,
    output logic                             illegal
);

    localparam int W      = aluPkg::DataWidth;
    localparam int ShBits = $clog2(W);

    logic               isSub;
    logic [W-1:0]       addIn2;
    logic [W-1:0]       addSum;
    logic signed [2*W-1:0] product;
    logic               lessSigned;
    logic               lessUnsigned;
    logic [7:0]         shAmt;
    logic               bigShift;
    logic [W-1:0]       sllOut;
    logic [W-1:0]       srlOut;
    logic [W-1:0]       sraOut;
    logic [W-1:0]       aluOut;
    logic               legal;
    logic               isDivOp;
    logic               divLoad;
    logic [W-1:0]       quotient;
    logic [W-1:0]       remainder;
    logic               divDone;
    logic               singleValid;
    logic               illegalQ;
    logic               divRem;
    logic [W-1:0]       resultQ;

    // Add and sub share one adder. Sub uses the inverted operand plus a carry in.
    assign isSub  = (ctl == aluPkg::CtlSub);
    assign addIn2 = isSub ? ~op2 : op2;
    assign addSum = op1 + addIn2 + {{(W-1){1'b0}}, isSub};

    assign product = $signed(op1) * $signed(op2);

    assign lessSigned   = $signed(op1) < $signed(op2);
    assign lessUnsigned = op1 < op2;

    // Shift amounts of 32 and above push every bit out.
    assign shAmt    = op2[7:0];
    assign bigShift = |shAmt[7:ShBits];
    assign sllOut   = bigShift ? '0 : op1 << shAmt[ShBits-1:0];
    assign srlOut   = bigShift ? '0 : op1 >> shAmt[ShBits-1:0];
    assign sraOut   = bigShift ? {W{op1[W-1]}}
                               : $unsigned($signed(op1) >>> shAmt[ShBits-1:0]);

    always_comb begin
        aluOut  = '0;
        legal   = 1'b1;
        isDivOp = 1'b0;
        case (ctl)
            aluPkg::CtlAdd,
            aluPkg::CtlSub:  aluOut = addSum;
            aluPkg::CtlMul:  aluOut = product[W-1:0];
            aluPkg::CtlMulh: aluOut = product[2*W-1:W];
            aluPkg::CtlDiv,
            aluPkg::CtlRem:  isDivOp = 1'b1;
            aluPkg::CtlSlt:  aluOut = {{(W-1){1'b0}}, lessSigned};
            aluPkg::CtlSltu: aluOut = {{(W-1){1'b0}}, lessUnsigned};
            aluPkg::CtlSll:  aluOut = sllOut;
            aluPkg::CtlSrl:  aluOut = srlOut;
            aluPkg::CtlSra:  aluOut = sraOut;
            aluPkg::CtlAnd:  aluOut = op1 & op2;
            aluPkg::CtlOr:   aluOut = op1 | op2;
            aluPkg::CtlXor:  aluOut = op1 ^ op2;
            aluPkg::CtlNot:  aluOut = ~op1;
            // Anything else is not exactly one defined code.
            default:         legal = 1'b0;
        endcase
    end

    assign divLoad = start & isDivOp;

    aluDivider i_aluDivider (
        .clk       (clk),
        .rstN      (rstN),
        .load      (divLoad),
        .dividend  (op1),
        .divisor   (op2),
        .quotient  (quotient),
        .remainder (remainder),
        .finished  (divDone)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            singleValid <= 1'b0;
            illegalQ    <= 1'b0;
            divRem      <= 1'b0;
        end else begin
            singleValid <= start & ~isDivOp;
            if (start) begin
                illegalQ <= ~legal;
                divRem   <= (ctl == aluPkg::CtlRem);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            resultQ <= aluOut;
        end
    end

    assign resValid = singleValid | divDone;
    assign result   = divDone ? (divRem ? remainder : quotient) : resultQ;
    assign illegal  = illegalQ;

endmodule

`default_nettype wire

/* design/aluDivider.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDivider (
    input  wire                              clk,
    input  wire                              rstN,
    input  wire                              load,
    input  wire  [aluPkg::DataWidth-1:0]     dividend,
    input  wire  [aluPkg::DataWidth-1:0]     divisor,
    output logic [aluPkg::DataWidth-1:0]     quotient,
    output logic [aluPkg::DataWidth-1:0]     remainder,
    output logic                             finished
);

    localparam int W        = aluPkg::DataWidth;
    localparam int CntWidth = $clog2(aluPkg::DivCycles + 1);

    logic [W-1:0]        quoReg;
    logic [W-1:0]        remReg;
    logic [W-1:0]        dvsReg;
    logic [CntWidth-1:0] count;
    logic                running;
    logic                finishedQ;
    logic [W:0]          shifted;
    logic [W:0]          diff;

    // Partial remainder with the next dividend bit shifted in.
    assign shifted = {remReg, quoReg[W-1]};
    assign diff    = shifted - {1'b0, dvsReg};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running   <= 1'b0;
            count     <= '0;
            finishedQ <= 1'b0;
        end else begin
            finishedQ <= 1'b0;
            if (load) begin
                running <= 1'b1;
                count   <= CntWidth'(aluPkg::DivCycles);
            end else if (running) begin
                count <= count - 1'b1;
                if (count == CntWidth'(1)) begin
                    running   <= 1'b0;
                    finishedQ <= 1'b1;
                end
            end
        end
    end

    // The quotient register doubles as the dividend shift register.
    // A zero divisor never fails the subtract, so all quotient bits become ones.
    always_ff @(posedge clk) begin
        if (load) begin
            quoReg <= dividend;
            remReg <= '0;
            dvsReg <= divisor;
        end else if (running) begin
            if (!diff[W]) begin
                remReg <= diff[W-1:0];
                quoReg <= {quoReg[W-2:0], 1'b1};
            end else begin
                remReg <= shifted[W-1:0];
                quoReg <= {quoReg[W-2:0], 1'b0};
            end
        end
    end

    assign quotient  = quoReg;
    assign remainder = remReg;
    assign finished  = finishedQ;

endmodule

`default_nettype wire

/* design/aluPkg.sv */
`default_nettype none

package aluPkg;

    // Operand and result width.
    localparam int DataWidth = 32;

    // Width of the one-hot control word.
    localparam int CtlWidth = 16;

    // One-hot operation codes. Bit 9 has no operation assigned.
    localparam logic [CtlWidth-1:0] CtlAdd  = 16'h0001;
    localparam logic [CtlWidth-1:0] CtlSub  = 16'h0002;
    localparam logic [CtlWidth-1:0] CtlMul  = 16'h0004;
    localparam logic [CtlWidth-1:0] CtlDiv  = 16'h0008;
    localparam logic [CtlWidth-1:0] CtlRem  = 16'h0010;
    localparam logic [CtlWidth-1:0] CtlMulh = 16'h0020;
    localparam logic [CtlWidth-1:0] CtlSlt  = 16'h0040;
    localparam logic [CtlWidth-1:0] CtlSltu = 16'h0080;
    localparam logic [CtlWidth-1:0] CtlSll  = 16'h0100;
    localparam logic [CtlWidth-1:0] CtlSrl  = 16'h0400;
    localparam logic [CtlWidth-1:0] CtlSra  = 16'h0800;
    localparam logic [CtlWidth-1:0] CtlAnd  = 16'h1000;
    localparam logic [CtlWidth-1:0] CtlOr   = 16'h2000;
    localparam logic [CtlWidth-1:0] CtlXor  = 16'h4000;
    localparam logic [CtlWidth-1:0] CtlNot  = 16'h8000;

    // APB register byte offsets.
    localparam logic [7:0] RegOp1    = 8'h00;
    localparam logic [7:0] RegOp2    = 8'h04;
    localparam logic [7:0] RegCtl    = 8'h08;
    localparam logic [7:0] RegResult = 8'h0C;
    localparam logic [7:0] RegStatus = 8'h10;

    // Bit positions in the status word.
    localparam int StatBusy    = 0;
    localparam int StatDone    = 1;
    localparam int StatIllegal = 2;

    // One quotient bit is produced per divider iteration.
    localparam int DivCycles = 32;

endpackage

`default_nettype wire

/* design/aluRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module aluRegs #(
    parameter int AddrWidth = 8
) (
    input  wire                              clk,
    input  wire                              rstN,
    input  wire                              psel,
    input  wire                              penable,
    input  wire                              pwrite,
    input  wire  [AddrWidth-1:0]             paddr,
    input  wire  [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic [aluPkg::DataWidth-1:0]     op1,
    output logic [aluPkg::DataWidth-1:0]     op2,
    output logic [aluPkg::CtlWidth-1:0]      ctl,
    output logic                             start,
    input  wire  [aluPkg::DataWidth-1:0]     resultReg,
    input  wire  [aluPkg::DataWidth-1:0]     status
);

    logic access;
    logic busy;
    logic hitOp1;
    logic hitOp2;
    logic hitCtl;
    logic hitResult;
    logic hitStatus;
    logic mapped;
    logic hitWritable;
    logic writeOk;

    // The slave never inserts wait states.
    assign pready = 1'b1;

    assign access = psel & penable;
    assign busy   = status[aluPkg::StatBusy];

    assign hitOp1    = (paddr == AddrWidth'(aluPkg::RegOp1));
    assign hitOp2    = (paddr == AddrWidth'(aluPkg::RegOp2));
    assign hitCtl    = (paddr == AddrWidth'(aluPkg::RegCtl));
    assign hitResult = (paddr == AddrWidth'(aluPkg::RegResult));
    assign hitStatus = (paddr == AddrWidth'(aluPkg::RegStatus));

    assign hitWritable = hitOp1 | hitOp2 | hitCtl;
    assign mapped      = hitWritable | hitResult | hitStatus;

    // Operand and control writes are dropped while an operation is running.
    assign writeOk = access & pwrite & hitWritable & ~busy;

    assign pslverr = access & (~mapped
                               | (pwrite & (hitResult | hitStatus))
                               | (pwrite & hitWritable & busy));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            op1   <= '0;
            op2   <= '0;
            ctl   <= '0;
            start <= 1'b0;
        end else begin
            // A control write launches the operation on the following cycle.
            start <= writeOk & hitCtl;
            if (writeOk & hitOp1) begin
                op1 <= pwdata[aluPkg::DataWidth-1:0];
            end
            if (writeOk & hitOp2) begin
                op2 <= pwdata[aluPkg::DataWidth-1:0];
            end
            if (writeOk & hitCtl) begin
                ctl <= pwdata[aluPkg::CtlWidth-1:0];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (psel & ~pwrite) begin
            if (hitOp1) begin
                prdata = op1;
            end else if (hitOp2) begin
                prdata = op2;
            end else if (hitCtl) begin
                prdata = {{(32 - aluPkg::CtlWidth){1'b0}}, ctl};
            end else if (hitResult) begin
                prdata = resultReg;
            end else if (hitStatus) begin
                prdata = status;
            end
        end
    end

endmodule

`default_nettype wire

/* design/aluResult.sv */
`timescale 1ns/1ps
`default_nettype none

module aluResult (
    input  wire                              clk,
    input  wire                              rstN,
    input  wire                              start,
    input  wire                              resValid,
    input  wire  [aluPkg::DataWidth-1:0]     result,
    input  wire                              illegal,
    output logic [aluPkg::DataWidth-1:0]     resultReg,
    output logic [aluPkg::DataWidth-1:0]     status
);

    logic busy;
    logic done;
    logic illegalReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            illegalReg <= 1'b0;
            resultReg  <= '0;
        end else if (start) begin
            busy       <= 1'b1;
            done       <= 1'b0;
            illegalReg <= 1'b0;
        end else if (resValid) begin
            busy       <= 1'b0;
            done       <= 1'b1;
            illegalReg <= illegal;
            resultReg  <= result;
        end
    end

    // Status word as seen by the bus master.
    always_comb begin
        status                      = '0;
        status[aluPkg::StatBusy]    = busy;
        status[aluPkg::StatDone]    = done;
        status[aluPkg::StatIllegal] = illegalReg;
    end

endmodule

`default_nettype wire

/* list.f */
design/aluPkg.sv
design/aluRegs.sv
design/aluDivider.sv
design/aluCore.sv
design/aluResult.sv
design/aluApbTop.sv
tb/aluApbAsserts.sv
tb/aluApbTb.sv

/* tb/aluApbAsserts.sv */
`timescale 1ns/1ps
`default_nettype none

module aluApbAsserts (
    input wire clk,
    input wire rstN,
    input wire psel,
    input wire penable,
    input wire pready,
    input wire pslverr,
    input wire start,
    input wire busy,
    input wire done
);

    // The slave never adds wait states.
    readyHigh: assert property (@(posedge clk) disable iff (!rstN) pready)
        else $error("pready went low");

    errorInAccess: assert property (@(posedge clk) disable iff (!rstN)
                                    pslverr |-> (psel && penable))
        else $error("pslverr high outside an APB access cycle");

    busyOrDone: assert property (@(posedge clk) disable iff (!rstN) !(busy && done))
        else $error("busy and done are both set");

    startPulse: assert property (@(posedge clk) disable iff (!rstN) start |=> !start)
        else $error("start stayed high for more than one cycle");

endmodule

bind aluApbTop aluApbAsserts i_aluApbAsserts (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .busy    (status[aluPkg::StatBusy]),
    .done    (status[aluPkg::StatDone])
);

`default_nettype wire

/* tb/aluApbTb.sv */
`timescale 1ns/1ps
`default_nettype none

module aluApbTb;

    localparam int AddrWidth = 8;
    localparam int ClkPeriod = 8;
    localparam int NumEdge   = 6;
    // Single-cycle runs, divide runs, illegal codes, busy test and bad accesses.
    localparam int NumOps        = 13 * (NumEdge + 2) + 8 + 3 + 1 + 1;
    localparam int TimeoutCycles = NumOps * 40 + 200;

    localparam logic [15:0] SingleCodes [13] = '{
        aluPkg::CtlAdd, aluPkg::CtlSub, aluPkg::CtlMul, aluPkg::CtlMulh,
        aluPkg::CtlSlt, aluPkg::CtlSltu, aluPkg::CtlSll, aluPkg::CtlSrl,
        aluPkg::CtlSra, aluPkg::CtlAnd, aluPkg::CtlOr, aluPkg::CtlXor, aluPkg::CtlNot
    };

    // Shift amounts 0, 31, 32 and 255, and operands with the sign bit set.
    localparam logic [31:0] EdgeA [NumEdge] = '{
        32'h0000_0005, 32'h8000_0001, 32'hdead_beef,
        32'h8765_4321, 32'h8000_0000, 32'h7fff_ffff
    };
    localparam logic [31:0] EdgeB [NumEdge] = '{
        32'h0000_0000, 32'h0000_001f, 32'h0000_0020,
        32'h0000_00ff, 32'hffff_ffff, 32'h8000_0000
    };

    logic                 clk;
    logic                 rstN;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AddrWidth-1:0] paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic [31:0]          lfsr;

    aluApbTop #(
        .AddrWidth (AddrWidth)
    ) i_aluApbTop (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic failAndStop();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            failAndStop();
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr     = {lfsr[30:0], feedback};
            value    = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Legal codes have one bit set, and bit 9 carries no operation.
    function automatic logic isLegal(input logic [15:0] code);
        return $onehot(code) && (code != 16'h0200);
    endfunction

    function automatic logic [31:0] modelResult(input logic [15:0] code,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
        logic signed [63:0] product;
        logic signed [31:0] arith;
        logic [7:0]         amount;
        product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        amount  = b[7:0];
        arith   = $signed(a) >>> amount;
        case (code)
            aluPkg::CtlAdd:  return a + b;
            aluPkg::CtlSub:  return a - b;
            aluPkg::CtlMul:  return product[31:0];
            aluPkg::CtlMulh: return product[63:32];
            aluPkg::CtlDiv:  return (b == 0) ? 32'hffff_ffff : a / b;
            aluPkg::CtlRem:  return (b == 0) ? a : a % b;
            aluPkg::CtlSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluPkg::CtlSltu: return (a < b) ? 32'd1 : 32'd0;
            aluPkg::CtlSll:  return (amount > 31) ? 32'd0 : a << amount;
            aluPkg::CtlSrl:  return (amount > 31) ? 32'd0 : a >> amount;
            aluPkg::CtlSra:  return (amount > 31) ? {32{a[31]}} : arith;
            aluPkg::CtlAnd:  return a & b;
            aluPkg::CtlOr:   return a | b;
            aluPkg::CtlXor:  return a ^ b;
            aluPkg::CtlNot:  return ~a;
            default:         return 32'd0;
        endcase
    endfunction

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        checkValue({31'd0, pready}, 32'd1, "pready in write access cycle");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data,
                           output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        checkValue({31'd0, pready}, 32'd1, "pready in read access cycle");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic waitDone(output logic [31:0] status);
        logic err;
        apbRead(aluPkg::RegStatus, status, err);
        while (!status[aluPkg::StatDone]) begin
            apbRead(aluPkg::RegStatus, status, err);
        end
    endtask

    task automatic runOperation(input logic [15:0] code, input logic [31:0] a,
                                input logic [31:0] b);
        logic        err;
        logic [31:0] status;
        logic [31:0] data;
        logic [31:0] expStatus;
        apbWrite(aluPkg::RegOp1, a, err);
        checkValue({31'd0, err}, 32'd0, "pslverr on RegOp1 write");
        apbWrite(aluPkg::RegOp2, b, err);
        checkValue({31'd0, err}, 32'd0, "pslverr on RegOp2 write");
        apbWrite(aluPkg::RegCtl, {16'd0, code}, err);
        checkValue({31'd0, err}, 32'd0, "pslverr on RegCtl write");
        if (code == aluPkg::CtlDiv || code == aluPkg::CtlRem) begin
            waitDone(status);
        end else begin
            apbRead(aluPkg::RegStatus, status, err);
        end
        expStatus                      = 32'd0;
        expStatus[aluPkg::StatDone]    = 1'b1;
        expStatus[aluPkg::StatIllegal] = ~isLegal(code);
        checkValue(status, expStatus, $sformatf("status after ctl 0x%04h", code));
        apbRead(aluPkg::RegResult, data, err);
        checkValue(data, modelResult(code, a, b),
                   $sformatf("result of ctl 0x%04h on 0x%08h, 0x%08h", code, a, b));
    endtask

    task automatic testReset();
        logic [31:0] data;
        logic        err;
        apbRead(aluPkg::RegStatus, data, err);
        checkValue(data, 32'd0, "status after reset");
        apbRead(aluPkg::RegResult, data, err);
        checkValue(data, 32'd0, "result after reset");
    endtask

    task automatic testSingleCycle();
        logic [31:0] a;
        logic [31:0] b;
        for (int c = 0; c < 13; c++) begin
            for (int e = 0; e < NumEdge; e++) begin
                runOperation(SingleCodes[c], EdgeA[e], EdgeB[e]);
            end
            a = randomBits(32);
            b = randomBits(32);
            runOperation(SingleCodes[c], a, b);
            // A short second operand keeps shift amounts in range.
            a = randomBits(32);
            b = randomBits(5);
            runOperation(SingleCodes[c], a, b);
        end
    endtask

    task automatic testDivide();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 3; i++) begin
            a = randomBits(32);
            b = randomBits(4 + 8 * i);
            runOperation(aluPkg::CtlDiv, a, b);
            runOperation(aluPkg::CtlRem, a, b);
        end
        a = randomBits(32);
        runOperation(aluPkg::CtlDiv, a, 32'd0);
        runOperation(aluPkg::CtlRem, a, 32'd0);
    endtask

    task automatic testIllegal();
        runOperation(16'h0000, 32'h1234_5678, 32'h9abc_def0);
        runOperation(16'h0003, 32'h1234_5678, 32'h9abc_def0);
        runOperation(16'h0200, 32'h1234_5678, 32'h9abc_def0);
    endtask

    task automatic testBusyWrites();
        logic        err;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] status;
        logic [31:0] data;
        a = randomBits(32);
        b = randomBits(16);
        apbWrite(aluPkg::RegOp1, a, err);
        apbWrite(aluPkg::RegOp2, b, err);
        apbWrite(aluPkg::RegCtl, {16'd0, aluPkg::CtlDiv}, err);
        checkValue({31'd0, err}, 32'd0, "pslverr on divide start");
        apbWrite(aluPkg::RegOp1, ~a, err);
        checkValue({31'd0, err}, 32'd1, "pslverr on RegOp1 write while busy");
        apbWrite(aluPkg::RegCtl, {16'd0, aluPkg::CtlAdd}, err);
        checkValue({31'd0, err}, 32'd1, "pslverr on RegCtl write while busy");
        waitDone(status);
        checkValue(status, 32'd2, "status after busy writes");
        apbRead(aluPkg::RegResult, data, err);
        checkValue(data, modelResult(aluPkg::CtlDiv, a, b), "quotient after busy writes");
        apbRead(aluPkg::RegOp1, data, err);
        checkValue(data, a, "RegOp1 after refused write");
    endtask

    task automatic testBadAccesses();
        logic        err;
        logic [31:0] data;
        runOperation(aluPkg::CtlXor, 32'h1234_5678, 32'h0f0f_0f0f);
        apbWrite(aluPkg::RegResult, 32'hffff_ffff, err);
        checkValue({31'd0, err}, 32'd1, "pslverr on RegResult write");
        apbWrite(aluPkg::RegStatus, 32'hffff_ffff, err);
        checkValue({31'd0, err}, 32'd1, "pslverr on RegStatus write");
        apbWrite(8'h14, 32'hffff_ffff, err);
        checkValue({31'd0, err}, 32'd1, "pslverr on unmapped write");
        apbRead(8'h40, data, err);
        checkValue({31'd0, err}, 32'd1, "pslverr on unmapped read");
        apbRead(aluPkg::RegResult, data, err);
        checkValue(data, 32'h1d3b_5977, "result after bad accesses");
        apbRead(aluPkg::RegStatus, data, err);
        checkValue(data, 32'd2, "status after bad accesses");
        apbRead(aluPkg::RegOp1, data, err);
        checkValue(data, 32'h1234_5678, "RegOp1 after bad accesses");
        apbRead(aluPkg::RegOp2, data, err);
        checkValue(data, 32'h0f0f_0f0f, "RegOp2 after bad accesses");
        apbRead(aluPkg::RegCtl, data, err);
        checkValue(data, {16'd0, aluPkg::CtlXor}, "RegCtl after bad accesses");
    endtask

    initial begin
        lfsr    = 32'h9e3b_79af;
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        testReset();
        testSingleCycle();
        testDivide();
        testIllegal();
        testBusyWrites();
        testBadAccesses();
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        failAndStop();
    end

endmodule

`default_nettype wire
